// File: bbox_pkg.sv
//##########################################################################
// Shared types for the triangle bounding-box stage of the rasterizer.
// Coordinates are signed fixed point, SIGFIG bits with RADIX fraction bits.
// Every stage module imports this package and passes tri_box_t items.
//##########################################################################

package bbox_pkg;

    // Total bits in one coordinate
    parameter int SIGFIG = 24;

    // Fraction bits in one coordinate
    parameter int RADIX = 10;

    // Signed fixed point
    // Integer part in [SIGFIG-1:RADIX], fraction in [RADIX-1:0]
    typedef logic signed [SIGFIG-1:0] coord_t;

    // One screen-space point
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Triangle as three vertices
    // Winding order is not used by this stage
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    // Axis-aligned bounding box
    // ll is the lower-left corner, ur the upper-right corner
    typedef struct packed {
        vertex_t ll;
        vertex_t ur;
    } box_t;

    // One-hot subsample grid
    // 1X keeps whole pixels, 4X half pixels,
    // 16X quarter pixels, 64X eighth pixels
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,
        MSAA_4X  = 4'b0100,
        MSAA_16X = 4'b0010,
        MSAA_64X = 4'b0001
    } msaa_e;

    // Item carried from stage to stage
    // Triangle rides along with its box so later sample tests see both
    typedef struct packed {
        logic    valid;
        tri_t    triangle;
        box_t    box;
    } tri_box_t;

endpackage

// File: bbox_extent.sv
//##########################################################################
// First pipeline stage: registers the incoming triangle together with
// its min/max bounding box. Holds everything while halt_n is low.
//##########################################################################

`timescale 1ns/1ps

module bbox_extent (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt_n,
    input  bbox_pkg::tri_t     tri_in,
    input  logic               tri_valid,
    output bbox_pkg::tri_box_t item
);

    import bbox_pkg::*;

    // Unregistered box of the input triangle
    box_t box_d;

    // Smallest of three coordinates
    // Signed compare since the arguments are coord_t
    function automatic coord_t min3(
        input coord_t a,
        input coord_t b,
        input coord_t c
    );
        coord_t m;
        m = (a <= b) ? a : b;
        // Ties give equal values, so the pick does not matter
        return (m <= c) ? m : c;
    endfunction

    // Largest of three coordinates
    function automatic coord_t max3(
        input coord_t a,
        input coord_t b,
        input coord_t c
    );
        coord_t m;
        m = (a >= b) ? a : b;
        return (m >= c) ? m : c;
    endfunction

    always_comb begin
        // Lower-left from the minima
        box_d.ll.x = min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        box_d.ll.y = min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
        // Upper-right from the maxima
        box_d.ur.x = max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        box_d.ur.y = max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
    end

    // Input register
    // Advances only when halt_n is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            item <= '0;
        end else if (halt_n) begin
            item.valid    <= tri_valid;
            item.triangle <= tri_in;
            item.box      <= box_d;
        end
    end

endmodule

// File: bbox_delay_line.sv
//##########################################################################
// Halt-enabled register chain between the extent and snap/clip stages.
// STAGES sets the number of registers; all shift together on an advance
// edge and keep their contents while halt_n is low.
//##########################################################################

`timescale 1ns/1ps

module bbox_delay_line #(
    parameter int STAGES = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt_n,
    input  bbox_pkg::tri_box_t item_in,
    output bbox_pkg::tri_box_t item_out
);

    import bbox_pkg::*;

    // Index 0 is nearest the input
    tri_box_t stage_q [STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Clear valid and payload in every slot
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else if (halt_n) begin
            stage_q[0] <= item_in;
            // Shift the rest one slot toward the output
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Oldest item goes to the consumer
    assign item_out = stage_q[STAGES-1];

endmodule

// File: bbox_snap_clip.sv
//##########################################################################
// Last pipeline stage: floors the box to the MSAA subsample grid, clamps
// it to the screen or rejects it when wholly off screen, and registers
// the box, the triangle and the valid bit onto the outputs.
//##########################################################################

`timescale 1ns/1ps

module bbox_snap_clip (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt_n,
    input  bbox_pkg::tri_box_t item_in,
    input  bbox_pkg::vertex_t  screen,
    input  bbox_pkg::msaa_e    msaa,
    output bbox_pkg::tri_t     tri_out,
    output bbox_pkg::box_t     box_out,
    output logic               box_valid
);

    import bbox_pkg::*;

    // Fraction bits that survive the snap
    logic [RADIX-1:0] frac_mask;

    // Snapped corners
    coord_t ll_x;
    coord_t ll_y;
    coord_t ur_x;
    coord_t ur_y;

    // Screen limits for the clamp and the reject test
    coord_t scr_x;
    coord_t scr_y;

    // Clamped box and result valid
    box_t box_d;
    logic reject;
    logic valid_d;

    // Mask for the fraction field
    // Top bit is half a pixel, next a quarter, next an eighth
    function automatic logic [RADIX-1:0] grid_mask(input msaa_e code);
        logic [RADIX-1:0] mask;
        case (code)
            MSAA_1X:  mask = '0;
            MSAA_4X:  mask = {3'b100, {(RADIX-3){1'b0}}};
            MSAA_16X: mask = {3'b110, {(RADIX-3){1'b0}}};
            MSAA_64X: mask = {3'b111, {(RADIX-3){1'b0}}};
            // Illegal codes fall back to whole pixels
            default:  mask = '0;
        endcase
        return mask;
    endfunction

    // Integer part kept and low fraction bits cleared
    // On two's complement this floors toward minus infinity
    function automatic coord_t snap(
        input coord_t           value,
        input logic [RADIX-1:0] mask
    );
        coord_t r;
        r = value;
        r[RADIX-1:0] = value[RADIX-1:0] & mask;
        return r;
    endfunction

    always_comb begin
        frac_mask = grid_mask(msaa);

        ll_x = snap(item_in.box.ll.x, frac_mask);
        ll_y = snap(item_in.box.ll.y, frac_mask);
        ur_x = snap(item_in.box.ur.x, frac_mask);
        ur_y = snap(item_in.box.ur.y, frac_mask);

        scr_x = screen.x;
        scr_y = screen.y;

        // Lower-left pulled up to the origin
        box_d.ll.x = (ll_x < 0) ? '0 : ll_x;
        box_d.ll.y = (ll_y < 0) ? '0 : ll_y;

        // Upper-right pulled down to the screen edge
        box_d.ur.x = (ur_x >= scr_x) ? scr_x : ur_x;
        box_d.ur.y = (ur_y >= scr_y) ? scr_y : ur_y;

        // Wholly left/below the origin or right/above the screen
        reject = (ur_x < 0) || (ur_y < 0) || (ll_x >= scr_x) || (ll_y >= scr_y);

        valid_d = item_in.valid && !reject;
    end

    // Output register
    // Triangle passes through untouched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_out   <= '0;
            box_out   <= '0;
            box_valid <= 1'b0;
        end else if (halt_n) begin
            tri_out   <= item_in.triangle;
            box_out   <= box_d;
            box_valid <= valid_d;
        end
    end

endmodule

// File: bbox_top.sv
//##########################################################################
// Bounding-box stage of the rasterizer. Extent stage, halt-enabled delay
// line and snap/clip stage in a chain of PIPE_DEPTH advance edges.
// halt_n low freezes every register; screen and msaa are config levels.
//##########################################################################

`timescale 1ns/1ps

module bbox_top #(
    // Total latency in advance edges (3 or more)
    parameter int PIPE_DEPTH = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              halt_n,
    input  bbox_pkg::tri_t    tri_in,
    input  logic              tri_valid,
    input  bbox_pkg::vertex_t screen,
    input  bbox_pkg::msaa_e   msaa,
    output bbox_pkg::tri_t    tri_out,
    output bbox_pkg::box_t    box_out,
    output logic              box_valid
);

    import bbox_pkg::*;

    // Extent stage to delay line
    tri_box_t extent_item;

    // Delay line to snap/clip stage
    tri_box_t delayed_item;

    // Min/max box in one advance edge
    bbox_extent u_extent (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .item      (extent_item)
    );

    // Middle of the pipe
    // Extent and snap/clip take one edge each and the rest sits here
    bbox_delay_line #(
        .STAGES (PIPE_DEPTH - 2)
    ) u_delay_line (
        .clk      (clk),
        .rst_n    (rst_n),
        .halt_n   (halt_n),
        .item_in  (extent_item),
        .item_out (delayed_item)
    );

    // Snap, clamp or reject in one advance edge
    bbox_snap_clip u_snap_clip (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .item_in   (delayed_item),
        .screen    (screen),
        .msaa      (msaa),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .box_valid (box_valid)
    );

endmodule

// File: bbox_checker.sv
//##########################################################################
// Scoreboard for the bounding-box pipeline. Predicts each output item from
// the inputs sampled on an advance edge, queues it for PIPE_DEPTH advance
// edges and compares it with the DUT outputs; also checks the halt hold.
//##########################################################################

`timescale 1ns/1ps

module bbox_checker #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt_n,
    input  bbox_pkg::tri_t     tri_in,
    input  logic               tri_valid,
    input  bbox_pkg::vertex_t  screen,
    input  bbox_pkg::msaa_e    msaa,
    input  bbox_pkg::tri_t     tri_out,
    input  bbox_pkg::box_t     box_out,
    input  logic               box_valid,
    output int                 error_count,
    output int                 check_count
);

    import bbox_pkg::*;

    // Items in flight with the oldest at the front
    tri_box_t expected_q [$];

    // Outputs seen at the previous edge for the hold check
    logic was_halted;
    tri_t held_tri;
    box_t held_box;
    logic held_valid;

    // Fraction bits that survive on each grid
    function automatic int kept_bits(input msaa_e m);
        case (m)
            MSAA_4X:  return 1;
            MSAA_16X: return 2;
            MSAA_64X: return 3;
            // 1X and illegal codes snap to whole pixels
            default:  return 0;
        endcase
    endfunction

    // Expected output item for one input triangle
    function automatic tri_box_t expected_item(
        input tri_t    t,
        input logic    v,
        input vertex_t scr,
        input msaa_e   m
    );
        coord_t   xs [3];
        coord_t   ys [3];
        coord_t   lo_x;
        coord_t   lo_y;
        coord_t   hi_x;
        coord_t   hi_y;
        coord_t   sx;
        coord_t   sy;
        int       shift;
        logic     off_screen;
        tri_box_t e;
        xs[0] = t.v0.x;
        xs[1] = t.v1.x;
        xs[2] = t.v2.x;
        ys[0] = t.v0.y;
        ys[1] = t.v1.y;
        ys[2] = t.v2.y;
        lo_x = xs[0];
        hi_x = xs[0];
        lo_y = ys[0];
        hi_y = ys[0];
        // Walk the vertices for the extremes
        for (int i = 1; i < 3; i++) begin
            if (xs[i] < lo_x) lo_x = xs[i];
            if (xs[i] > hi_x) hi_x = xs[i];
            if (ys[i] < lo_y) lo_y = ys[i];
            if (ys[i] > hi_y) hi_y = ys[i];
        end
        // Floor to a multiple of the grid step by an arithmetic shift pair
        shift = RADIX - kept_bits(m);
        lo_x = (lo_x >>> shift) <<< shift;
        lo_y = (lo_y >>> shift) <<< shift;
        hi_x = (hi_x >>> shift) <<< shift;
        hi_y = (hi_y >>> shift) <<< shift;
        sx = scr.x;
        sy = scr.y;
        // Box entirely outside the visible area
        off_screen = (hi_x < 0) || (hi_y < 0) || (lo_x >= sx) || (lo_y >= sy);
        e.valid    = v && !off_screen;
        e.triangle = t;
        e.box.ll.x = (lo_x < 0) ? '0 : lo_x;
        e.box.ll.y = (lo_y < 0) ? '0 : lo_y;
        e.box.ur.x = (hi_x >= sx) ? sx : hi_x;
        e.box.ur.y = (hi_y >= sy) ? sy : hi_y;
        return e;
    endfunction

    // Valid is always compared and the payload only when asked
    task automatic compare_outputs(
        input tri_box_t want,
        input logic     with_data,
        input string    phase
    );
        check_count++;
        if (box_valid !== want.valid) begin
            error_count++;
            $display("** Error: box_valid expected %h actual %h (%s) at %0t",
                     want.valid, box_valid, phase, $time);
        end
        if (with_data && (box_out !== want.box)) begin
            error_count++;
            $display("** Error: box_out expected %h actual %h (%s) at %0t",
                     want.box, box_out, phase, $time);
        end
        if (with_data && (tri_out !== want.triangle)) begin
            error_count++;
            $display("** Error: tri_out expected %h actual %h (%s) at %0t",
                     want.triangle, tri_out, phase, $time);
        end
    endtask

    always @(posedge clk) begin
        tri_box_t expected;
        tri_box_t blank;
        blank = '0;
        if (!rst_n) begin
            // Every stage leaves reset holding an invalid item
            expected_q.delete();
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                expected_q.push_back(blank);
            end
            was_halted = 1'b0;
        end else begin
            // A halted edge must not have moved the outputs
            if (was_halted) begin
                expected.valid    = held_valid;
                expected.triangle = held_tri;
                expected.box      = held_box;
                compare_outputs(expected, 1'b1, "hold");
            end
            if (halt_n) begin
                expected_q.push_back(expected_item(tri_in, tri_valid, screen, msaa));
                expected = expected_q.pop_front();
                compare_outputs(expected, expected.valid, "pipe");
            end
            was_halted = !halt_n;
            held_valid = box_valid;
            held_tri   = tri_out;
            held_box   = box_out;
        end
    end

endmodule

// File: tb_bbox.sv
//##########################################################################
// Testbench for the bounding-box pipeline. Makes clock and reset, drives
// xorshift triangles through five tests and leaves all comparing to the
// checker module; prints one line per test and a closing summary.
//##########################################################################

`timescale 1ns/1ps

module tb_bbox;

    import bbox_pkg::*;

    // Latency of the DUT in advance edges
    localparam int PIPE_DEPTH  = 3;
    localparam int NUM_TESTS   = 5;
    // Nominal length of one test
    localparam int TEST_CYCLES = 200;
    // Twice the nominal run covers drains and reset
    localparam int CYCLE_LIMIT = 2 * NUM_TESTS * TEST_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        halt_n;
    logic        tri_valid;
    tri_t        tri_in;
    vertex_t     screen;
    msaa_e       msaa;
    tri_t        tri_out;
    box_t        box_out;
    logic        box_valid;

    // Counters from the checker
    int          error_count;
    int          check_count;

    logic [31:0] rng_state;
    int          cycle_count;
    int          tests_passed;
    int          tests_failed;
    int          errors_at_start;
    int          checks_at_start;

    bbox_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .screen    (screen),
        .msaa      (msaa),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .box_valid (box_valid)
    );

    bbox_checker #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_checker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .halt_n      (halt_n),
        .tri_in      (tri_in),
        .tri_valid   (tri_valid),
        .screen      (screen),
        .msaa        (msaa),
        .tri_out     (tri_out),
        .box_out     (box_out),
        .box_valid   (box_valid),
        .error_count (error_count),
        .check_count (check_count)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Whole pixels to fixed point
    function automatic coord_t to_fixed(input int px);
        int full;
        full = px * (1 << RADIX);
        return full[SIGFIG-1:0];
    endfunction

    // Random coordinate in [lo_px, lo_px + span_px) with random fraction
    function automatic coord_t random_coord(input int lo_px, input int span_px);
        int full;
        rng_state = xorshift32(rng_state);
        full = lo_px * (1 << RADIX) + int'(rng_state % (span_px * (1 << RADIX)));
        return full[SIGFIG-1:0];
    endfunction

    function automatic tri_t random_triangle(
        input int x_lo,
        input int x_span,
        input int y_lo,
        input int y_span
    );
        tri_t t;
        t.v0.x = random_coord(x_lo, x_span);
        t.v0.y = random_coord(y_lo, y_span);
        t.v1.x = random_coord(x_lo, x_span);
        t.v1.y = random_coord(y_lo, y_span);
        t.v2.x = random_coord(x_lo, x_span);
        t.v2.y = random_coord(y_lo, y_span);
        return t;
    endfunction

    // One cycle of stimulus
    task automatic drive_cycle(input logic run, input logic valid, input tri_t t);
        @(posedge clk);
        halt_n    <= run;
        tri_valid <= valid;
        tri_in    <= t;
    endtask

    // Flush the pipe with invalid items
    task automatic drain();
        repeat (PIPE_DEPTH + 2) drive_cycle(1'b1, 1'b0, '0);
    endtask

    // Screen and grid change only on an empty pipe
    task automatic set_config(input int width, input int height, input msaa_e code);
        @(posedge clk);
        screen.x  <= to_fixed(width);
        screen.y  <= to_fixed(height);
        msaa      <= code;
        halt_n    <= 1'b1;
        tri_valid <= 1'b0;
    endtask

    task automatic send_stream(
        input int count,
        input int x_lo,
        input int x_span,
        input int y_lo,
        input int y_span
    );
        repeat (count) drive_cycle(1'b1, 1'b1, random_triangle(x_lo, x_span, y_lo, y_span));
    endtask

    task automatic begin_test();
        @(negedge clk);
        errors_at_start = error_count;
        checks_at_start = check_count;
    endtask

    task automatic end_test(input int num, input string name);
        drain();
        @(negedge clk);
        if (error_count == errors_at_start && check_count > checks_at_start) begin
            tests_passed++;
            $display("Test %0d (%s): passed, %0d compares", num, name,
                     check_count - checks_at_start);
        end else if (error_count != errors_at_start) begin
            tests_failed++;
            $display("Test %0d (%s): failed with %0d value errors", num, name,
                     error_count - errors_at_start);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): failed, no outputs were compared", num, name);
        end
    endtask

    // All four grids over the same screen
    task automatic sweep_msaa();
        msaa_e codes [4];
        codes[0] = MSAA_1X;
        codes[1] = MSAA_4X;
        codes[2] = MSAA_16X;
        codes[3] = MSAA_64X;
        for (int i = 0; i < 4; i++) begin
            set_config(640, 480, codes[i]);
            send_stream(40, 0, 640, 0, 480);
            drain();
        end
    endtask

    // Mix of partial overhang and wholly off-screen triangles
    task automatic send_overhang(input int count);
        logic [2:0] mode;
        tri_t       t;
        repeat (count) begin
            rng_state = xorshift32(rng_state);
            mode = rng_state[2:0];
            // Off to the right, left, above and below, else partial overhang
            case (mode)
                3'd0:    t = random_triangle(660, 240, 0, 480);
                3'd1:    t = random_triangle(-300, 295, 0, 480);
                3'd2:    t = random_triangle(0, 640, 500, 300);
                3'd3:    t = random_triangle(0, 640, -300, 295);
                default: t = random_triangle(-150, 940, -150, 780);
            endcase
            drive_cycle(1'b1, 1'b1, t);
        end
    endtask

    // Random halts on about one cycle in four
    task automatic send_with_halts(input int count);
        logic run;
        logic valid;
        tri_t t;
        repeat (count) begin
            rng_state = xorshift32(rng_state);
            run   = rng_state[3] | rng_state[7];
            valid = rng_state[11] | rng_state[5];
            t     = random_triangle(-100, 840, -100, 680);
            drive_cycle(run, valid, t);
        end
    endtask

    initial begin
        rng_state    = 32'h34dc098c;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        halt_n       = 1'b1;
        tri_valid    = 1'b0;
        tri_in       = '0;
        screen.x     = to_fixed(640);
        screen.y     = to_fixed(480);
        msaa         = MSAA_1X;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        repeat (20) drive_cycle(1'b1, 1'b0, '0);
        end_test(1, "idle after reset");

        begin_test();
        set_config(640, 480, MSAA_1X);
        send_stream(150, 0, 640, 0, 480);
        end_test(2, "random triangles, 1x grid");

        begin_test();
        sweep_msaa();
        end_test(3, "all msaa grids");

        begin_test();
        set_config(640, 480, MSAA_64X);
        send_overhang(150);
        end_test(4, "clamp and reject");

        begin_test();
        set_config(640, 480, MSAA_4X);
        send_with_halts(200);
        end_test(5, "random halts");

        $display("Tests passed: %0d, tests failed: %0d, value errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: bbox_raster.f
bbox_pkg.sv
bbox_extent.sv
bbox_delay_line.sv
bbox_snap_clip.sv
bbox_top.sv
bbox_checker.sv
tb_bbox.sv

// File: run_sim.sh
#!/bin/sh
# Build the bounding-box pipeline and its testbench with Verilator,
# run the simulation and decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG" &&
verilator --binary --timing -j 0 --top-module tb_bbox -f bbox_raster.f -o tb_bbox &&
./obj_dir/tb_bbox > "$LOG" 2>&1 ||
echo "Build or run stopped early"

cat "$LOG" 2>/dev/null

grep -q "SIMULATION PASSED" "$LOG" 2>/dev/null && echo "Result: pass" && exit 0 ||
{
    echo "Result: fail"
    exit 1
}
